// File: rtl/axis_part_pkg.sv
// Stream partitioner shared definitions.
// Holds the default widths, the stream beat and configuration types
// and the APB register map used by the register block.

package axis_part_pkg;

    // Default widths, overridden through the top-level parameters.
    localparam int DATA_W = 8;    // Used data bits per beat.
    localparam int LEN_W  = 16;   // Partition length and beat index.

    // One stream beat between FIFO, partitioner and top-level ports.
    typedef struct packed {
        logic [31:0] data;        // Low DATA_W bits carry payload.
        logic        last;        // End of input packet.
    } axis_beat_t;

    // Software configuration driven by the register block.
    typedef struct packed {
        logic        valve;       // 1 passes beats, 0 holds them.
        logic [15:0] part_len;    // Last beat index of a segment.
    } part_cfg_t;

    // APB register offsets.
    localparam logic [11:0] REG_CTRL = 12'h000;   // Bit 0 is the valve.
    localparam logic [11:0] REG_LEN  = 12'h004;   // Partition length.
    localparam logic [11:0] REG_SEGS = 12'h008;   // Segment count, read-only.

endpackage

// File: rtl/axis_part_regs.sv
// APB configuration registers for the stream partitioner.
// Holds the valve and the partition length, and counts the
// segments completed by the partitioner. Zero wait states;
// unmapped offsets and writes to the counter raise pslverr.

`timescale 1ns/100ps

module axis_part_regs #(
    parameter int LEN_W = axis_part_pkg::LEN_W
) (
    input  logic                     aclk,
    input  logic                     rst_n,
    // APB slave.
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [11:0]              paddr,
    input  logic [31:0]              pwdata,
    output logic [31:0]              prdata,
    output logic                     pready,
    output logic                     pslverr,
    // Partitioner side.
    output axis_part_pkg::part_cfg_t cfg,
    input  logic                     seg_done
);

    logic             valve_q;
    logic [LEN_W-1:0] len_q;
    logic [31:0]      segs_q;

    logic access;
    logic hit_ctrl;
    logic hit_len;
    logic hit_segs;
    logic wr_ok;

    assign access   = psel && penable;   // APB access phase.
    assign hit_ctrl = (paddr == axis_part_pkg::REG_CTRL);
    assign hit_len  = (paddr == axis_part_pkg::REG_LEN);
    assign hit_segs = (paddr == axis_part_pkg::REG_SEGS);

    // Only the two writable registers accept data.
    assign wr_ok = access && pwrite && (hit_ctrl || hit_len);

    assign pready = 1'b1;   // No wait states.

    always_comb begin
        pslverr = 1'b0;
        if (access) begin
            if (!(hit_ctrl || hit_len || hit_segs)) begin
                pslverr = 1'b1;   // Unmapped offset.
            end else if (pwrite && hit_segs) begin
                pslverr = 1'b1;   // Counter is read-only.
            end
        end
    end

    // Read data, zero on errors and outside the access phase.
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            if (hit_ctrl) begin
                prdata = {31'b0, valve_q};
            end else if (hit_len) begin
                prdata = 32'(len_q);
            end else if (hit_segs) begin
                prdata = segs_q;
            end
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            valve_q <= 1'b0;
            len_q   <= '0;
        end else if (wr_ok) begin
            if (hit_ctrl) begin
                valve_q <= pwdata[0];
            end
            if (hit_len) begin
                len_q <= pwdata[LEN_W-1:0];
            end
        end
    end

    // Completed segments, wraps at 2^32.
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            segs_q <= '0;
        end else if (seg_done) begin
            segs_q <= segs_q + 32'd1;
        end
    end

    assign cfg.valve    = valve_q;
    assign cfg.part_len = 16'(len_q);

endmodule

// File: rtl/axis_beat_fifo.sv
// Synchronous FIFO for stream beats.
// Circular buffer with read and write pointers and a fill count.
// Valid/ready on both sides; one cycle from write to read.

`timescale 1ns/100ps

module axis_beat_fifo #(
    parameter int DEPTH  = 8,
    parameter int DATA_W = axis_part_pkg::DATA_W
) (
    input  logic                      aclk,
    input  logic                      rst_n,
    // Write side.
    input  logic                      wr_valid,
    input  axis_part_pkg::axis_beat_t wr_beat,
    output logic                      wr_ready,
    // Read side.
    output logic                      rd_valid,
    output axis_part_pkg::axis_beat_t rd_beat,
    input  logic                      rd_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Stored entry is {last, data[DATA_W-1:0]}.
    logic [DATA_W:0] mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_nxt;
    logic             ready_q;

    logic push;
    logic pop;

    assign push = wr_valid && wr_ready;
    assign pop  = rd_valid && rd_ready;

    always_comb begin
        count_nxt = count;
        if (push && !pop) begin
            count_nxt = count + CNT_W'(1);
        end else if (pop && !push) begin
            count_nxt = count - CNT_W'(1);
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            ready_q <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            count   <= count_nxt;
            ready_q <= (count_nxt != CNT_W'(DEPTH));   // Registered not-full.
        end
    end

    // Payload storage.
    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= {wr_beat.last, wr_beat.data[DATA_W-1:0]};
        end
    end

    assign wr_ready = ready_q;
    assign rd_valid = (count != '0);

    // Unused upper data bits read back as zero.
    always_comb begin
        rd_beat      = '0;
        rd_beat.data = 32'(mem[rd_ptr][DATA_W-1:0]);
        rd_beat.last = mem[rd_ptr][DATA_W];
    end

endmodule

// File: rtl/axis_partitioner.sv
// Stream partitioner core.
// Gates the stream with the software valve, counts beats within
// the current segment and inserts tlast when the segment reaches
// part_len or the input packet ends. Data path is combinational;
// only the beat counter and the segment pulse are registered.

`timescale 1ns/100ps

module axis_partitioner #(
    parameter int LEN_W = axis_part_pkg::LEN_W
) (
    input  logic                      aclk,
    input  logic                      rst_n,
    // Configuration from the register block.
    input  axis_part_pkg::part_cfg_t  cfg,
    // Source side, from the FIFO.
    input  logic                      src_valid,
    input  axis_part_pkg::axis_beat_t src_beat,
    output logic                      src_ready,
    // Output stream.
    output logic                      out_valid,
    output axis_part_pkg::axis_beat_t out_beat,
    output logic [LEN_W-1:0]          out_tcnt,
    input  logic                      out_ready,
    // One-cycle pulse per completed segment.
    output logic                      seg_done
);

    logic [LEN_W-1:0] cnt;        // Index of the current beat.
    logic [LEN_W-1:0] part_len;
    logic             len_hit;
    logic             seg_end;
    logic             xfer;

    assign part_len = LEN_W'(cfg.part_len);

    // A closed valve hides the FIFO head and stalls it.
    assign out_valid = cfg.valve && src_valid;
    assign src_ready = cfg.valve && out_ready;

    assign xfer = out_valid && out_ready;

    // Greater-or-equal also closes a segment when the length is
    // lowered below the running count.
    assign len_hit = (cnt >= part_len);
    assign seg_end = src_beat.last || len_hit;

    always_comb begin
        out_beat      = src_beat;
        out_beat.last = seg_end;
    end

    assign out_tcnt = cnt;

    // Beat counter, restarts after each segment end.
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (xfer) begin
            if (seg_end) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + LEN_W'(1);
            end
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            seg_done <= 1'b0;
        end else begin
            seg_done <= xfer && seg_end;   // Counted by the registers.
        end
    end

endmodule

// File: rtl/axis_part_top.sv
// Stream partitioner top level.
// Input beats are buffered in a FIFO, then cut into segments of
// at most part_len + 1 beats behind a software valve. An APB
// register block sets the valve and length and counts segments.

`timescale 1ns/100ps

module axis_part_top #(
    parameter int DATA_W = axis_part_pkg::DATA_W,
    parameter int LEN_W  = axis_part_pkg::LEN_W,
    parameter int DEPTH  = 8
) (
    input  logic                      aclk,
    input  logic                      rst_n,
    // APB configuration port.
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [11:0]               paddr,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    // Input stream.
    input  logic                      in_valid,
    input  axis_part_pkg::axis_beat_t in_beat,
    output logic                      in_ready,
    // Output stream.
    output logic                      out_valid,
    output axis_part_pkg::axis_beat_t out_beat,
    output logic [LEN_W-1:0]          out_tcnt,
    input  logic                      out_ready
);

    axis_part_pkg::part_cfg_t  cfg;
    axis_part_pkg::axis_beat_t fifo_beat;
    logic                      fifo_valid;
    logic                      fifo_ready;
    logic                      seg_done;

    axis_part_regs #(
        .LEN_W    (LEN_W)
    ) regs_i (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .cfg      (cfg),
        .seg_done (seg_done)
    );

    axis_beat_fifo #(
        .DEPTH    (DEPTH),
        .DATA_W   (DATA_W)
    ) fifo_i (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .wr_valid (in_valid),
        .wr_beat  (in_beat),
        .wr_ready (in_ready),
        .rd_valid (fifo_valid),
        .rd_beat  (fifo_beat),
        .rd_ready (fifo_ready)
    );

    axis_partitioner #(
        .LEN_W     (LEN_W)
    ) part_i (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .src_valid (fifo_valid),
        .src_beat  (fifo_beat),
        .src_ready (fifo_ready),
        .out_valid (out_valid),
        .out_beat  (out_beat),
        .out_tcnt  (out_tcnt),
        .out_ready (out_ready),
        .seg_done  (seg_done)
    );

endmodule

// File: sim/axis_part_sva.sv
// Protocol checker for the stream partitioner.
// Bound into the partitioner for the output stream and into the
// register block for the APB slave. Ports a target lacks are tied off.
// Failures are also counted for the testbench summary.

`timescale 1ns/100ps

module axis_part_sva #(
    parameter int LEN_W = axis_part_pkg::LEN_W
) (
    input  logic                      aclk,
    input  logic                      rst_n,
    input  axis_part_pkg::part_cfg_t  cfg,
    input  logic                      out_valid,
    input  logic                      out_ready,
    input  axis_part_pkg::axis_beat_t out_beat,
    input  logic [LEN_W-1:0]          out_tcnt,
    input  logic                      pready
);

    int unsigned fail_cnt;   // Failed assertion count.

    initial fail_cnt = 0;

    // A stalled beat holds until it moves, unless the valve closes.
    property beat_held;
        @(posedge aclk) disable iff (!rst_n)
            out_valid && !out_ready |=>
                !cfg.valve || (out_valid && $stable(out_beat) && $stable(out_tcnt));
    endproperty

    property tcnt_in_range;
        @(posedge aclk) disable iff (!rst_n)
            out_tcnt <= LEN_W'(cfg.part_len);
    endproperty

    property pready_high;
        @(posedge aclk) disable iff (!rst_n)
            pready;
    endproperty

    assert property (beat_held)
        else begin
            $error("output beat changed or dropped during a stall");
            fail_cnt++;
        end
    assert property (tcnt_in_range)
        else begin
            $error("out_tcnt is above part_len");
            fail_cnt++;
        end
    assert property (pready_high)
        else begin
            $error("pready went low");
            fail_cnt++;
        end

endmodule

// File: sim/tb_axis_part.sv
// Testbench for the stream partitioner.
// Configures the block over APB, sends random packets and
// compares every output beat with a model of the segment rule.

`timescale 1ns/100ps

module tb_axis_part;

    localparam int          DATA_W = axis_part_pkg::DATA_W;
    localparam int          LEN_W  = axis_part_pkg::LEN_W;
    localparam logic [31:0] SEED   = 32'h5a79a212;

    // Expected output beat.
    typedef struct packed {
        logic [31:0]      data;
        logic             last;
        logic [LEN_W-1:0] tcnt;
    } exp_beat_t;

    logic                      aclk;
    logic                      rst_n;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [11:0]               paddr;
    logic [31:0]               pwdata;
    logic [31:0]               prdata;
    logic                      pready;
    logic                      pslverr;
    logic                      in_valid;
    axis_part_pkg::axis_beat_t in_beat;
    logic                      in_ready;
    logic                      out_valid;
    axis_part_pkg::axis_beat_t out_beat;
    logic [LEN_W-1:0]          out_tcnt;
    logic                      out_ready;

    axis_part_pkg::axis_beat_t in_q [$];   // Accepted, not yet seen at output.
    int          errors;
    int          checks;
    int          tests;
    int          err_mark;
    int          exp_idx;
    int          in_cnt;
    int          xfer_cnt;
    int          last_cnt;
    int unsigned plen_model;
    bit          random_ready;
    bit          saw_full;
    logic [31:0] stim_lfsr;
    logic [31:0] rdy_lfsr;

    axis_part_top #(
        .DATA_W (DATA_W),
        .LEN_W  (LEN_W),
        .DEPTH  (8)
    ) dut_i (
        .aclk (aclk), .rst_n (rst_n),
        .psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr),
        .pwdata (pwdata), .prdata (prdata), .pready (pready), .pslverr (pslverr),
        .in_valid (in_valid), .in_beat (in_beat), .in_ready (in_ready),
        .out_valid (out_valid), .out_beat (out_beat), .out_tcnt (out_tcnt),
        .out_ready (out_ready)
    );

    bind axis_partitioner axis_part_sva #(.LEN_W(LEN_W)) part_sva_i (
        .aclk (aclk), .rst_n (rst_n), .cfg (cfg), .out_valid (out_valid),
        .out_ready (out_ready), .out_beat (out_beat), .out_tcnt (out_tcnt),
        .pready (1'b1)
    );

    bind axis_part_regs axis_part_sva #(.LEN_W(LEN_W)) regs_sva_i (
        .aclk (aclk), .rst_n (rst_n), .cfg (cfg), .out_valid (1'b0),
        .out_ready (1'b0), .out_beat ('0), .out_tcnt ('0), .pready (pready)
    );

    // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v         = {v[30:0], stim_lfsr[0]};
            stim_lfsr = lfsr_step(stim_lfsr);
        end
        return v;
    endfunction

    // Segment rule. Last on packet end or when the index reaches part_len.
    function automatic exp_beat_t ref_beat(input axis_part_pkg::axis_beat_t b,
                                           input int unsigned idx,
                                           input int unsigned plen);
        exp_beat_t e;
        e.data = 32'(b.data[DATA_W-1:0]);
        e.last = b.last || (idx == plen);
        e.tcnt = LEN_W'(idx);
        return e;
    endfunction

    task automatic check_eq(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic check_cond(input bit ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("ERROR at %0t: %s", $time, what);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("ERROR at %0t: timed out waiting for %s", $time, what);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s: %s, %0d errors", tests, name,
                 (errors == err_mark) ? "ok" : "failed", errors - err_mark);
        err_mark = errors;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             output logic err);
        @(negedge aclk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge aclk);
        penable = 1'b1;
        @(posedge aclk);
        err = pslverr;
        @(negedge aclk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
                            output logic err);
        @(negedge aclk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge aclk);
        penable = 1'b1;
        @(posedge aclk);
        data = prdata;
        err  = pslverr;
        @(negedge aclk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic set_len(input int unsigned len);
        logic err;
        apb_write(axis_part_pkg::REG_LEN, 32'(len), err);
        check_cond(!err, "pslverr on a length write");
        plen_model = len;
    endtask

    task automatic set_valve(input logic open);
        logic err;
        apb_write(axis_part_pkg::REG_CTRL, {31'b0, open}, err);
        check_cond(!err, "pslverr on a control write");
    endtask

    // Called on a falling edge; each beat is held until in_ready.
    task automatic send_packet(input int len);
        int n;
        for (int i = 0; i < len; i++) begin
            in_beat      = '0;
            in_beat.data = 32'(rand_bits(DATA_W));
            in_beat.last = (i == len - 1);
            in_valid     = 1'b1;
            n = 0;
            while (!in_ready) begin
                @(negedge aclk);
                n++;
                if (n > 300) stop_on_timeout("in_ready");
            end
            @(negedge aclk);
        end
        in_valid = 1'b0;
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (in_q.size() != 0) begin
            @(negedge aclk);
            n++;
            if (n > 1000) stop_on_timeout("the output to drain");
        end
    endtask

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    initial begin
        out_ready = 1'b1;
        forever begin
            @(negedge aclk);
            if (random_ready) begin
                out_ready = rdy_lfsr[0];
                rdy_lfsr  = lfsr_step(rdy_lfsr);
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    // Output compare and input capture, sampled before the edge updates.
    always @(posedge aclk) begin : monitor
        axis_part_pkg::axis_beat_t b;
        exp_beat_t                 e;
        if (rst_n) begin
            if (in_valid && !in_ready) saw_full = 1'b1;
            if (out_valid && out_ready) begin
                xfer_cnt++;
                if (out_beat.last) last_cnt++;
                check_cond(in_q.size() != 0, "output beat with no input beat pending");
                if (in_q.size() != 0) begin
                    b = in_q.pop_front();
                    e = ref_beat(b, exp_idx, plen_model);
                    check_eq("out data", out_beat.data, e.data);
                    check_eq("out last", 32'(out_beat.last), 32'(e.last));
                    check_eq("out tcnt", 32'(out_tcnt), 32'(e.tcnt));
                    exp_idx = e.last ? 0 : exp_idx + 1;
                end
            end
            if (in_valid && in_ready) begin
                in_q.push_back(in_beat);
                in_cnt++;
            end
        end
    end

    initial begin
        logic [31:0] rd;
        logic        err;
        int          mark;
        int          plens [3];
        plens = '{0, 3, 15};
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        in_valid = 1'b0;
        in_beat = '0;
        rst_n = 1'b0;
        {errors, checks, tests, err_mark, exp_idx} = '0;
        {in_cnt, xfer_cnt, last_cnt} = '0;
        plen_model = 0;
        random_ready = 1'b0;
        saw_full = 1'b0;
        stim_lfsr = SEED;
        rdy_lfsr = SEED;
        repeat (16) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;

        apb_read(axis_part_pkg::REG_SEGS, rd, err);
        check_eq("segments after reset", rd, 32'd0);
        apb_write(axis_part_pkg::REG_CTRL, 32'd1, err);
        apb_read(axis_part_pkg::REG_CTRL, rd, err);
        check_eq("ctrl readback", rd, 32'd1);
        check_cond(!err, "pslverr on a valid ctrl read");
        apb_write(axis_part_pkg::REG_CTRL, 32'd0, err);
        apb_read(axis_part_pkg::REG_CTRL, rd, err);
        check_eq("ctrl readback", rd, 32'd0);
        apb_write(axis_part_pkg::REG_LEN, 32'h0000_a5c3, err);
        apb_read(axis_part_pkg::REG_LEN, rd, err);
        check_eq("len readback", rd, 32'h0000_a5c3);
        apb_read(12'h010, rd, err);
        check_cond(err, "no pslverr on a read of an unmapped offset");
        check_eq("unmapped read data", rd, 32'd0);
        apb_write(12'h010, 32'hffff_ffff, err);
        check_cond(err, "no pslverr on a write to an unmapped offset");
        apb_write(axis_part_pkg::REG_SEGS, 32'd5, err);
        check_cond(err, "no pslverr on a write to the segment counter");
        finish_test("registers");

        set_len(15);
        set_valve(1'b1);
        repeat (4) send_packet(1 + int'(rand_bits(4)));
        wait_drained();
        check_eq("beats out versus in", xfer_cnt, in_cnt);
        finish_test("data order");

        foreach (plens[i]) begin
            set_len(plens[i]);
            repeat (5) send_packet(1 + int'(rand_bits(5)));
            wait_drained();
        end
        finish_test("partitioning");

        set_valve(1'b0);
        mark = xfer_cnt;
        fork
            send_packet(12);
            begin
                repeat (50) @(negedge aclk);
                check_eq("transfers with the valve closed", xfer_cnt - mark, 0);
                check_cond(!in_ready, "in_ready high with the valve closed and the FIFO full");
                set_valve(1'b1);
            end
        join
        wait_drained();
        finish_test("valve");

        set_len(3);
        random_ready = 1'b1;
        saw_full = 1'b0;
        repeat (6) send_packet(1 + int'(rand_bits(5)));
        wait_drained();
        random_ready = 1'b0;
        check_cond(saw_full, "in_ready never dropped under back-pressure");
        check_eq("beats out versus in", xfer_cnt, in_cnt);
        finish_test("back-pressure");

        apb_read(axis_part_pkg::REG_SEGS, rd, err);
        check_eq("segment count", rd, last_cnt);
        finish_test("segment count");

        check_cond(dut_i.part_i.part_sva_i.fail_cnt == 0,
                   "a stream protocol assertion failed");
        check_cond(dut_i.regs_i.regs_sva_i.fail_cnt == 0,
                   "an APB protocol assertion failed");
        finish_test("protocol");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: axis_partition.f
rtl/axis_part_pkg.sv
rtl/axis_part_regs.sv
rtl/axis_beat_fifo.sv
rtl/axis_partitioner.sv
rtl/axis_part_top.sv
sim/axis_part_sva.sv
sim/tb_axis_part.sv
